// File: design/rf_ctrl_pkg.sv
`default_nettype none

package rf_ctrl_pkg;

  // ==============================
  // Widths that carry a meaning
  // ==============================
  typedef logic [4:0]  ioc_t;       // Register index inside a block
  typedef logic [7:0]  reg_byte_t;  // Register data byte
  typedef logic [31:0] iq_word_t;   // I in 31:16, Q in 15:0

  // RF switch / LNA operating mode
  typedef enum logic [1:0] {
    RF_LOW_POWER = 2'd0,
    RF_RX09      = 2'd1,
    RF_TX09      = 2'd2,
    RF_BYPASS    = 2'd3
  } rf_mode_e;

  // Block select field of the SPI command byte
  localparam logic [1:0] MOD_SYS  = 2'd0;
  localparam logic [1:0] MOD_IO   = 2'd1;
  localparam logic [1:0] MOD_SMI  = 2'd2;
  localparam logic [1:0] MOD_RSVD = 2'd3;  // Nothing behind it

  localparam reg_byte_t FW_VERSION = 8'h01;
  localparam reg_byte_t RSVD_READ  = 8'hA5;  // Pattern for the unused block

  // ==============================
  // Register map
  // ==============================
  localparam ioc_t IOC_VERSION = 5'd1;  // System block
  localparam ioc_t IOC_DEBUG   = 5'd2;
  localparam ioc_t IOC_RF_MODE = 5'd1;  // I/O block
  localparam ioc_t IOC_INPUTS  = 5'd2;
  localparam ioc_t IOC_STATUS  = 5'd1;  // SMI block
  localparam ioc_t IOC_CLEAR   = 5'd2;

  // Sync pairs framing a sample word
  localparam logic [1:0] I_SYNC = 2'b10;  // Bits 31:30
  localparam logic [1:0] Q_SYNC = 2'b01;  // Bits 15:14

endpackage

`default_nettype wire

// File: design/spi_slave.sv
`default_nettype none

module spi_slave import rf_ctrl_pkg::*; (
  input  wire            i_glob_clock,
  input  wire            i_rst_b,
  input  wire            i_sck,
  input  wire            i_ss,
  input  wire            i_mosi,
  input  wire reg_byte_t i_sys_rd_data,
  input  wire reg_byte_t i_io_rd_data,
  input  wire reg_byte_t i_smi_rd_data,
  output logic           o_miso,
  output ioc_t           o_ioc,
  output reg_byte_t      o_wr_data,
  output logic [2:0]     o_cs,         // One-hot, bit per block
  output logic           o_fetch,
  output logic           o_load
);

  typedef enum logic [1:0] {ST_IDLE, ST_CMD, ST_DATA} spi_state_e;

  spi_state_e r_state;
  logic [2:0] r_sck_sync;   // Two sync stages plus one of history
  logic [2:0] r_ss_sync;
  logic [1:0] r_mosi_sync;  // Same delay as the SCK sync
  logic [2:0] r_bit_cnt;
  logic [7:0] r_shift_in;
  reg_byte_t  r_shift_out;
  logic       r_write;      // Write flag of the current frame
  logic [1:0] r_blk;
  logic       r_fetch_d;    // Blocks have their byte ready now
  logic       r_miso;
  reg_byte_t  sel_rd_data;
  logic       sck_rise, sck_fall, ss_fall, ss_high, cmd_done, data_done;

  assign sck_rise  = r_sck_sync[1] & ~r_sck_sync[2];
  assign sck_fall  = ~r_sck_sync[1] & r_sck_sync[2];
  assign ss_fall   = ~r_ss_sync[1] & r_ss_sync[2];
  assign ss_high   = r_ss_sync[1];
  assign cmd_done  = (r_state == ST_CMD) & sck_rise & (r_bit_cnt == 3'd7) & ~ss_high;
  assign data_done = (r_state == ST_DATA) & sck_rise & (r_bit_cnt == 3'd7) & ~ss_high;
  assign o_miso    = r_miso & ~i_ss;  // Quiet while deselected

  always_comb begin
    case (r_blk)
      MOD_SYS: sel_rd_data = i_sys_rd_data;
      MOD_IO:  sel_rd_data = i_io_rd_data;
      MOD_SMI: sel_rd_data = i_smi_rd_data;
      default: sel_rd_data = RSVD_READ;
    endcase
  end

  // ==============================
  // Frame control
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_sck_sync  <= 3'b000;
      r_ss_sync   <= 3'b111;  // Deselected
      r_mosi_sync <= 2'b00;
      r_state     <= ST_IDLE;
      r_bit_cnt   <= 3'd0;
      o_cs        <= 3'b000;
      o_fetch     <= 1'b0;
      o_load      <= 1'b0;
      r_fetch_d   <= 1'b0;
      r_miso      <= 1'b0;
    end else begin
      r_sck_sync  <= {r_sck_sync[1:0], i_sck};
      r_ss_sync   <= {r_ss_sync[1:0], i_ss};
      r_mosi_sync <= {r_mosi_sync[0], i_mosi};
      o_fetch     <= cmd_done & ~r_shift_in[6];  // Read command
      o_load      <= data_done & r_write;
      r_fetch_d   <= o_fetch;
      if (cmd_done) begin
        o_cs <= (r_shift_in[5:4] == MOD_RSVD) ? 3'b000 : (3'b001 << r_shift_in[5:4]);
      end
      if (ss_high) begin
        r_state <= ST_IDLE;  // Abort, nothing issued
        r_miso  <= 1'b0;
      end else begin
        if (sck_rise) r_bit_cnt <= r_bit_cnt + 3'd1;
        case (r_state)
          ST_IDLE: if (ss_fall) begin
            r_state   <= ST_CMD;
            r_bit_cnt <= 3'd0;
          end
          ST_CMD:  if (cmd_done) r_state <= ST_DATA;
          ST_DATA: if (data_done) r_state <= ST_IDLE;
          default: r_state <= ST_IDLE;
        endcase
        if (sck_fall && r_state == ST_DATA && !r_write) r_miso <= r_shift_out[7];
      end
    end
  end

  // Command, data and MISO byte
  always_ff @(posedge i_glob_clock) begin
    if (sck_rise) r_shift_in <= {r_shift_in[6:0], r_mosi_sync[1]};
    if (cmd_done) begin
      r_write <= r_shift_in[6];
      r_blk   <= r_shift_in[5:4];
      o_ioc   <= {r_shift_in[3:0], r_mosi_sync[1]};
    end
    if (data_done) o_wr_data <= {r_shift_in[6:0], r_mosi_sync[1]};
    if (r_fetch_d) r_shift_out <= sel_rd_data;
    else if (sck_fall && r_state == ST_DATA) r_shift_out <= {r_shift_out[6:0], 1'b0};
  end

endmodule

`default_nettype wire

// File: design/sys_ctrl.sv
`default_nettype none

module sys_ctrl import rf_ctrl_pkg::*; (
  input  wire            i_glob_clock,
  input  wire            i_rst_b,
  input  wire ioc_t      i_ioc,
  input  wire reg_byte_t i_wr_data,
  input  wire            i_cs,
  input  wire            i_fetch,
  input  wire            i_load,
  output reg_byte_t      o_rd_data,
  output logic           o_test_mode  // SMI counting pattern instead of FIFO
);

  // Debug register, bit 0 only
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      o_test_mode <= 1'b0;
    end else if (i_cs && i_load && i_ioc == IOC_DEBUG) begin
      o_test_mode <= i_wr_data[0];
    end
  end

  // Read byte captured on fetch
  always_ff @(posedge i_glob_clock) begin
    if (i_cs && i_fetch) begin
      case (i_ioc)
        IOC_VERSION: o_rd_data <= FW_VERSION;
        IOC_DEBUG:   o_rd_data <= {7'd0, o_test_mode};
        default:     o_rd_data <= 8'h00;  // Unmapped
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/io_ctrl.sv
`default_nettype none

module io_ctrl import rf_ctrl_pkg::*; (
  input  wire            i_glob_clock,
  input  wire            i_rst_b,
  input  wire ioc_t      i_ioc,
  input  wire reg_byte_t i_wr_data,
  input  wire            i_cs,
  input  wire            i_fetch,
  input  wire            i_load,
  input  wire            i_button,
  input  wire [3:0]      i_config,
  output reg_byte_t      o_rd_data,
  output logic           o_rx_h_tx_l,
  output logic           o_rx_h_tx_l_b,
  output logic           o_tr_vc1,
  output logic           o_tr_vc1_b,
  output logic           o_tr_vc2,
  output logic           o_shdn_rx_lna,
  output logic           o_shdn_tx_lna
);

  rf_mode_e r_rf_mode;

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_rf_mode <= RF_LOW_POWER;  // Both LNAs off
    end else if (i_cs && i_load && i_ioc == IOC_RF_MODE) begin
      r_rf_mode <= rf_mode_e'(i_wr_data[1:0]);
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (i_cs && i_fetch) begin
      case (i_ioc)
        IOC_RF_MODE: o_rd_data <= {6'd0, r_rf_mode};
        IOC_INPUTS:  o_rd_data <= {3'd0, i_button, i_config};  // Raw pins
        default:     o_rd_data <= 8'h00;
      endcase
    end
  end

  // ==============================
  // Switch and LNA decode
  // ==============================
  always_comb begin
    o_rx_h_tx_l   = 1'b1;  // Low-power defaults
    o_tr_vc1      = 1'b0;
    o_tr_vc2      = 1'b0;
    o_shdn_rx_lna = 1'b1;
    o_shdn_tx_lna = 1'b1;
    case (r_rf_mode)
      RF_RX09: begin
        o_tr_vc1      = 1'b1;
        o_shdn_rx_lna = 1'b0;  // RX LNA on
      end
      RF_TX09: begin
        o_rx_h_tx_l   = 1'b0;
        o_tr_vc2      = 1'b1;
        o_shdn_tx_lna = 1'b0;  // TX LNA on
      end
      RF_BYPASS: o_tr_vc2 = 1'b1;
      default: ;             // RF_LOW_POWER
    endcase
  end

  assign o_rx_h_tx_l_b = ~o_rx_h_tx_l;  // Differential switch drive
  assign o_tr_vc1_b    = ~o_tr_vc1;

endmodule

`default_nettype wire

// File: design/lvds_rx.sv
`default_nettype none

module lvds_rx import rf_ctrl_pkg::*; (
  input  wire       i_glob_clock,
  input  wire       i_rst_b,
  input  wire [1:0] i_rx_bits,     // First bit in bit 1
  input  wire       i_fifo_full,
  output logic      o_push,
  output iq_word_t  o_word,
  output logic      o_overflow     // Word lost, FIFO full
);

  typedef enum logic [1:0] {ST_IDLE, ST_I_HALF, ST_Q_HALF} rx_state_e;

  rx_state_e  r_state;
  logic [3:0] r_pair_cnt;  // Pair index inside the word, sync pair is 0
  logic       r_word_done;

  // Shift on every cycle, the word is complete when r_word_done is set
  always_ff @(posedge i_glob_clock) begin
    o_word <= {o_word[29:0], i_rx_bits};
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_state     <= ST_IDLE;
      r_pair_cnt  <= 4'd0;
      r_word_done <= 1'b0;
    end else begin
      r_word_done <= 1'b0;
      r_pair_cnt  <= r_pair_cnt + 4'd1;
      case (r_state)
        ST_IDLE: begin
          r_pair_cnt <= 4'd1;  // Next pair is index 1
          if (i_rx_bits == I_SYNC) r_state <= ST_I_HALF;
        end
        ST_I_HALF: begin
          if (r_pair_cnt == 4'd7) r_state <= ST_Q_HALF;
        end
        ST_Q_HALF: begin
          if (r_pair_cnt == 4'd8 && i_rx_bits != Q_SYNC) begin
            r_state <= ST_IDLE;  // Bad Q sync, drop it
          end else if (r_pair_cnt == 4'd15) begin
            r_state     <= ST_IDLE;
            r_word_done <= 1'b1;
          end
        end
        default: r_state <= ST_IDLE;
      endcase
    end
  end

  // ==============================
  // Push or flag the drop
  // ==============================
  assign o_push     = r_word_done & ~i_fifo_full;
  assign o_overflow = r_word_done & i_fifo_full;

endmodule

`default_nettype wire

// File: design/sample_fifo.sv
`default_nettype none

module sample_fifo import rf_ctrl_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 4
) (
  input  wire           i_glob_clock,
  input  wire           i_rst_b,
  input  wire           i_push,
  input  wire iq_word_t i_wr_data,
  input  wire           i_pull,
  output iq_word_t      o_rd_data,  // Head word, valid while not empty
  output logic          o_empty,
  output logic          o_full
);

  localparam int DEPTH = 2 ** FIFO_ADDR_WIDTH;

  iq_word_t                 mem [DEPTH];
  logic [FIFO_ADDR_WIDTH:0] r_wr_ptr;  // Extra MSB tells full from empty
  logic [FIFO_ADDR_WIDTH:0] r_rd_ptr;

  assign o_empty = (r_wr_ptr == r_rd_ptr);
  assign o_full  = (r_wr_ptr[FIFO_ADDR_WIDTH] != r_rd_ptr[FIFO_ADDR_WIDTH]) &&
                   (r_wr_ptr[FIFO_ADDR_WIDTH-1:0] == r_rd_ptr[FIFO_ADDR_WIDTH-1:0]);
  assign o_rd_data = mem[r_rd_ptr[FIFO_ADDR_WIDTH-1:0]];  // Show-ahead

  always_ff @(posedge i_glob_clock) begin
    if (i_push && !o_full) mem[r_wr_ptr[FIFO_ADDR_WIDTH-1:0]] <= i_wr_data;
  end

  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_wr_ptr <= '0;
      r_rd_ptr <= '0;
    end else begin
      if (i_push && !o_full) r_wr_ptr <= r_wr_ptr + 1'b1;  // Push on full is lost
      if (i_pull && !o_empty) r_rd_ptr <= r_rd_ptr + 1'b1;
    end
  end

endmodule

`default_nettype wire

// File: design/smi_ctrl.sv
`default_nettype none

module smi_ctrl import rf_ctrl_pkg::*; (
  input  wire            i_glob_clock,
  input  wire            i_rst_b,
  input  wire ioc_t      i_ioc,
  input  wire reg_byte_t i_wr_data,
  input  wire            i_cs,
  input  wire            i_fetch,
  input  wire            i_load,
  input  wire            i_test_mode,
  input  wire iq_word_t  i_fifo_data,
  input  wire            i_fifo_empty,
  input  wire            i_fifo_full,
  input  wire            i_overflow,
  input  wire            i_smi_a2,      // High selects the RX read direction
  input  wire            i_smi_soe_se,  // Read strobe, active low
  output reg_byte_t      o_rd_data,
  output logic           o_fifo_pull,
  output logic [7:0]     o_smi_data,
  output logic           o_smi_data_oe,
  output logic           o_smi_read_req
);

  logic [2:0] r_soe_sync;   // Two sync stages plus history
  logic [1:0] r_byte_idx;   // Byte of the word presented next
  iq_word_t   r_shift;      // Remaining bytes, next one on top
  iq_word_t   r_test_cnt;
  logic       r_overflow;   // Sticky until cleared by the host
  logic       strobe, word_start, word_avail;
  iq_word_t   src_word;

  assign strobe      = ~r_soe_sync[1] & r_soe_sync[2] & i_smi_a2;  // SOE falling edge
  assign word_start  = strobe & (r_byte_idx == 2'd0);
  assign word_avail  = i_test_mode | ~i_fifo_empty;
  assign src_word    = i_test_mode ? r_test_cnt : i_fifo_data;
  assign o_fifo_pull = word_start & ~i_test_mode & ~i_fifo_empty;

  assign o_smi_data_oe  = i_smi_a2 & ~i_smi_soe_se;  // Straight from the pins
  assign o_smi_read_req = i_smi_a2 & (~i_fifo_empty | (r_byte_idx != 2'd0) | i_test_mode);

  // ==============================
  // Strobe and byte sequencing
  // ==============================
  always_ff @(posedge i_glob_clock) begin
    if (!i_rst_b) begin
      r_soe_sync <= 3'b111;  // Strobe idles high
      r_byte_idx <= 2'd0;
      r_test_cnt <= '0;
      r_overflow <= 1'b0;
    end else begin
      r_soe_sync <= {r_soe_sync[1:0], i_smi_soe_se};
      if (strobe && (r_byte_idx != 2'd0 || word_avail)) r_byte_idx <= r_byte_idx + 2'd1;
      if (word_start && i_test_mode) r_test_cnt <= r_test_cnt + 32'd1;
      if (i_overflow) begin
        r_overflow <= 1'b1;  // Set wins over clear
      end else if (i_cs && i_load && i_ioc == IOC_CLEAR && i_wr_data[0]) begin
        r_overflow <= 1'b0;
      end
    end
  end

  always_ff @(posedge i_glob_clock) begin
    if (word_start) begin
      o_smi_data <= word_avail ? src_word[31:24] : 8'h00;  // Empty gives zero
      r_shift    <= {src_word[23:0], 8'h00};
    end else if (strobe) begin
      o_smi_data <= r_shift[31:24];
      r_shift    <= {r_shift[23:0], 8'h00};
    end
  end

  // Status register, full and empty live
  always_ff @(posedge i_glob_clock) begin
    if (i_cs && i_fetch) begin
      case (i_ioc)
        IOC_STATUS: o_rd_data <= {5'd0, r_overflow, i_fifo_full, i_fifo_empty};
        default:    o_rd_data <= 8'h00;
      endcase
    end
  end

endmodule

`default_nettype wire

// File: design/rf_ctrl_top.sv
`default_nettype none

module rf_ctrl_top import rf_ctrl_pkg::*; #(
  parameter int FIFO_ADDR_WIDTH = 4  // 16 words
) (
  input  wire       i_glob_clock,
  input  wire       i_rst_b,
  input  wire       i_sck,
  input  wire       i_ss,
  input  wire       i_mosi,
  input  wire [1:0] i_rx_bits,
  input  wire       i_button,
  input  wire [3:0] i_config,
  input  wire       i_smi_a2,
  input  wire       i_smi_soe_se,
  output logic      o_miso,
  output logic      o_rx_h_tx_l,
  output logic      o_rx_h_tx_l_b,
  output logic      o_tr_vc1,
  output logic      o_tr_vc1_b,
  output logic      o_tr_vc2,
  output logic      o_shdn_rx_lna,
  output logic      o_shdn_tx_lna,
  output logic [7:0] o_smi_data,
  output logic      o_smi_data_oe,
  output logic      o_smi_read_req
);

  // ==============================
  // Register bus
  // ==============================
  ioc_t       w_ioc;
  reg_byte_t  w_wr_data;
  logic [2:0] w_cs;  // SYS, IO, SMI from bit 0 up
  logic       w_fetch, w_load, w_test_mode;
  reg_byte_t  w_sys_rd, w_io_rd, w_smi_rd;

  // Sample path
  iq_word_t   w_rx_word, w_fifo_data;
  logic       w_push, w_overflow, w_pull, w_empty, w_full;

  spi_slave spi_slave_ins (.i_glob_clock, .i_rst_b, .i_sck, .i_ss, .i_mosi,
    .i_sys_rd_data(w_sys_rd), .i_io_rd_data(w_io_rd), .i_smi_rd_data(w_smi_rd),
    .o_miso, .o_ioc(w_ioc), .o_wr_data(w_wr_data), .o_cs(w_cs),
    .o_fetch(w_fetch), .o_load(w_load));

  sys_ctrl sys_ctrl_ins (.i_glob_clock, .i_rst_b, .i_ioc(w_ioc), .i_wr_data(w_wr_data),
    .i_cs(w_cs[0]), .i_fetch(w_fetch), .i_load(w_load), .o_rd_data(w_sys_rd),
    .o_test_mode(w_test_mode));

  io_ctrl io_ctrl_ins (.i_glob_clock, .i_rst_b, .i_ioc(w_ioc), .i_wr_data(w_wr_data),
    .i_cs(w_cs[1]), .i_fetch(w_fetch), .i_load(w_load), .i_button, .i_config,
    .o_rd_data(w_io_rd), .o_rx_h_tx_l, .o_rx_h_tx_l_b, .o_tr_vc1, .o_tr_vc1_b,
    .o_tr_vc2, .o_shdn_rx_lna, .o_shdn_tx_lna);

  lvds_rx lvds_rx_ins (.i_glob_clock, .i_rst_b, .i_rx_bits, .i_fifo_full(w_full),
    .o_push(w_push), .o_word(w_rx_word), .o_overflow(w_overflow));

  sample_fifo #(.FIFO_ADDR_WIDTH(FIFO_ADDR_WIDTH)) rx_fifo (.i_glob_clock, .i_rst_b,
    .i_push(w_push), .i_wr_data(w_rx_word), .i_pull(w_pull), .o_rd_data(w_fifo_data),
    .o_empty(w_empty), .o_full(w_full));

  smi_ctrl smi_ctrl_ins (.i_glob_clock, .i_rst_b, .i_ioc(w_ioc), .i_wr_data(w_wr_data),
    .i_cs(w_cs[2]), .i_fetch(w_fetch), .i_load(w_load), .i_test_mode(w_test_mode),
    .i_fifo_data(w_fifo_data), .i_fifo_empty(w_empty), .i_fifo_full(w_full),
    .i_overflow(w_overflow), .i_smi_a2, .i_smi_soe_se, .o_rd_data(w_smi_rd),
    .o_fifo_pull(w_pull), .o_smi_data, .o_smi_data_oe, .o_smi_read_req);

endmodule

`default_nettype wire

// File: testbench/tb_rf_ctrl.sv
`default_nettype none

module tb_rf_ctrl;
  timeunit 1ns;
  timeprecision 1ps;

  localparam TRACE_FILE = "testbench/rf_trace.txt";

  logic       glob_clock = 1'b0;
  logic       rst_b, sck, ss, mosi, button, smi_a2, smi_soe_se;
  logic [1:0] rx_bits;
  logic [3:0] cfg_pins;
  logic       miso, rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2;
  logic       shdn_rx_lna, shdn_tx_lna, smi_data_oe, smi_read_req;
  logic [7:0] smi_data;

  int    n_checks, n_errors, n_tests, test_checks, test_errors;
  int    budget;      // Trace operations weighted by word counts
  string test_name;

  always #5 glob_clock = ~glob_clock;  // 10 ns

  rf_ctrl_top #(.FIFO_ADDR_WIDTH(4)) i_dut (
    .i_glob_clock(glob_clock), .i_rst_b(rst_b), .i_sck(sck), .i_ss(ss), .i_mosi(mosi),
    .i_rx_bits(rx_bits), .i_button(button), .i_config(cfg_pins), .i_smi_a2(smi_a2),
    .i_smi_soe_se(smi_soe_se), .o_miso(miso), .o_rx_h_tx_l(rx_h_tx_l),
    .o_rx_h_tx_l_b(rx_h_tx_l_b), .o_tr_vc1(tr_vc1), .o_tr_vc1_b(tr_vc1_b),
    .o_tr_vc2(tr_vc2), .o_shdn_rx_lna(shdn_rx_lna), .o_shdn_tx_lna(shdn_tx_lna),
    .o_smi_data(smi_data), .o_smi_data_oe(smi_data_oe), .o_smi_read_req(smi_read_req)
  );

  task automatic check_equal(input logic [31:0] got, input logic [31:0] exp,
                             input string what);
    n_checks++;
    test_checks++;
    if (got !== exp) begin
      $display("[ERROR] %0d ns: %s, got %0h, expected %0h", $time, what, got, exp);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic verify_field_count(input int got, input int want, input logic [7:0] op);
    if (got != want) begin
      $display("Trace line with opcode '%c' is malformed", op);
      n_errors++;
      test_errors++;
    end
  endtask

  task automatic finish_test();
    $display("Test %s done: %0d checks, %0d errors", test_name, test_checks, test_errors);
    n_tests++;
    test_checks = 0;
    test_errors = 0;
  endtask

  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != 10 && c != -1) c = $fgetc(fd);  // Up to newline or EOF
  endtask

  task automatic count_trace_ops(input int fd, output int ops);
    logic [7:0]  op;
    logic [31:0] word;
    int          count;
    ops = 0;
    while ($fscanf(fd, " %c", op) == 1) begin
      if (op == "L" || op == "M") begin
        void'($fscanf(fd, " %h %d", word, count));
        ops += count;  // One slot per word
      end else if (op != "#") begin
        ops += 1;
      end
      skip_line(fd);
    end
  endtask

  // ==============================
  // Host side drivers
  // ==============================
  task automatic spi_transfer(input logic is_write, input logic [1:0] blk,
                              input logic [4:0] ioc, input logic [7:0] data,
                              output logic [7:0] rd);
    logic [15:0] frame;
    logic [15:0] miso_bits;
    int          i;
    frame     = {is_write, blk, ioc, data};
    miso_bits = '0;
    @(posedge glob_clock);
    ss <= 1'b0;
    repeat (4) @(posedge glob_clock);
    for (i = 15; i >= 0; i--) begin
      mosi <= frame[i];  // Mode 0 data changes while SCK is low
      sck  <= 1'b0;
      repeat (7) @(posedge glob_clock);
      @(negedge glob_clock);
      miso_bits = {miso_bits[14:0], miso};  // Host samples just before the rise
      @(posedge glob_clock);
      sck <= 1'b1;
      repeat (8) @(posedge glob_clock);
    end
    sck <= 1'b0;
    repeat (8) @(posedge glob_clock);
    ss <= 1'b1;
    repeat (8) @(posedge glob_clock);  // Gap so the next SS fall is seen
    rd = miso_bits[7:0];
  endtask

  task automatic send_lvds_word(input logic [31:0] word);
    int p;
    for (p = 15; p >= 0; p--) begin
      @(posedge glob_clock);
      rx_bits <= word[2*p +: 2];  // Pair 0 is bits 31:30
    end
    repeat (4) begin
      @(posedge glob_clock);
      rx_bits <= 2'b00;  // Idle pairs
    end
  endtask

  task automatic read_smi_word(output logic [31:0] got);
    int b;
    got = '0;
    @(posedge glob_clock);
    smi_a2 <= 1'b1;
    repeat (4) @(posedge glob_clock);
    for (b = 0; b < 4; b++) begin
      smi_soe_se <= 1'b0;  // Strobe low 8 cycles
      repeat (7) @(posedge glob_clock);
      @(negedge glob_clock);
      got = {got[23:0], smi_data};  // MSB arrives first
      check_equal(32'(smi_data_oe), 32'd1, "SMI output enable during strobe");
      @(posedge glob_clock);
      smi_soe_se <= 1'b1;
      repeat (7) @(posedge glob_clock);
      @(negedge glob_clock);
      check_equal(32'(smi_data_oe), 32'd0, "SMI output enable between strobes");
      @(posedge glob_clock);
    end
  endtask

  // ==============================
  // Trace runner
  // ==============================
  initial begin
    int          fd, code, k;
    logic [7:0]  op, data, rd;
    logic [1:0]  blk;
    logic [4:0]  ioc;
    logic [31:0] word, got;
    int          count;
    rst_b      = 1'b0;
    sck        = 1'b0;
    ss         = 1'b1;
    mosi       = 1'b0;
    rx_bits    = 2'b00;
    button     = 1'b1;
    cfg_pins   = 4'hA;  // Inputs register reads 8'h1A
    smi_a2     = 1'b0;
    smi_soe_se = 1'b1;
    fd = $fopen(TRACE_FILE, "r");
    if (fd == 0) begin
      $display("Could not open the trace file %s", TRACE_FILE);
      $display("TB FAILED");
      $finish;
    end else begin
      count_trace_ops(fd, budget);
      $fclose(fd);
      fd = $fopen(TRACE_FILE, "r");
      repeat (8) @(posedge glob_clock);
      rst_b <= 1'b1;
      repeat (2) @(posedge glob_clock);
      test_name = "reset_pins";
      @(negedge glob_clock);
      check_equal(32'(miso), 32'd0, "MISO after reset");
      check_equal(32'(smi_data_oe), 32'd0, "SMI output enable after reset");
      while ($fscanf(fd, " %c", op) == 1) begin
        case (op)
          "#": skip_line(fd);
          "T": begin
            finish_test();
            code = $fscanf(fd, " %s", test_name);
            verify_field_count(code, 1, op);
          end
          "W": begin
            code = $fscanf(fd, " %h %h %h", blk, ioc, data);
            verify_field_count(code, 3, op);
            spi_transfer(1'b1, blk, ioc, data, rd);
          end
          "R": begin
            code = $fscanf(fd, " %h %h %h", blk, ioc, data);
            verify_field_count(code, 3, op);
            spi_transfer(1'b0, blk, ioc, 8'h00, rd);
            check_equal(32'(rd), 32'(data), $sformatf("SPI read block %0d ioc %0h", blk, ioc));
          end
          "L": begin
            code = $fscanf(fd, " %h %d", word, count);
            verify_field_count(code, 2, op);
            for (k = 0; k < count; k++) send_lvds_word(word + 32'(k));
          end
          "M": begin
            code = $fscanf(fd, " %h %d", word, count);
            verify_field_count(code, 2, op);
            for (k = 0; k < count; k++) begin
              read_smi_word(got);
              check_equal(got, word + 32'(k), $sformatf("SMI word %0d after %0h", k, word));
            end
          end
          "Q": begin
            code = $fscanf(fd, " %h", data);
            verify_field_count(code, 1, op);
            @(posedge glob_clock);
            smi_a2 <= 1'b1;
            repeat (4) @(posedge glob_clock);
            @(negedge glob_clock);
            check_equal(32'(smi_read_req), 32'(data), "SMI read request");
          end
          "P": begin
            code = $fscanf(fd, " %h", data);
            verify_field_count(code, 1, op);
            @(negedge glob_clock);
            check_equal(32'({rx_h_tx_l, rx_h_tx_l_b, tr_vc1, tr_vc1_b, tr_vc2,
                             shdn_rx_lna, shdn_tx_lna}), 32'(data), "RF outputs");
          end
          default: begin
            $display("Unknown opcode '%c' in the trace file", op);
            n_errors++;
            test_errors++;
            skip_line(fd);
          end
        endcase
      end
      finish_test();
      $fclose(fd);
      $display("Summary: %0d tests, %0d checks, %0d errors", n_tests, n_checks, n_errors);
      if (n_errors == 0) begin
        $display("TB PASSED");
      end else begin
        $display("TB FAILED");
      end
      $finish;
    end
  end

  // Watchdog allows 3000 ns per trace operation
  initial begin
    wait (budget > 0);
    #(budget * 3000 + 1000);
    $display("Watchdog expired: the run timed out at %0d ns", $time);
    $display("TB FAILED");
    $finish;
  end

endmodule

`default_nettype wire

// File: build.f
design/rf_ctrl_pkg.sv
design/spi_slave.sv
design/sys_ctrl.sv
design/io_ctrl.sv
design/lvds_rx.sv
design/sample_fifo.sv
design/smi_ctrl.sv
design/rf_ctrl_top.sv
testbench/tb_rf_ctrl.sv

// File: Makefile
# Verilator build and run of the RF control testbench
TOP := tb_rf_ctrl

.PHONY: all lint clean

# Build, run, then look for the pass line in the log
all:
	verilator --binary --timing -Mdir obj_dir --top-module $(TOP) -f build.f
	obj_dir/V$(TOP) 2>&1 | tee sim.log
	grep -q "^TB PASSED$$" sim.log

# Lint of the design top level
lint:
	verilator --lint-only -Wall --timing --top-module rf_ctrl_top -f build.f

clean:
	rm -rf obj_dir sim.log

// File: testbench/rf_trace.txt
# W blk ioc data | R blk ioc expected | L first_word count | M first_word count
# Q read_req | P {rx,rx_b,vc1,vc1_b,vc2,shdn_rx,shdn_tx} | T name; hex except counts
T reset
P 4B
Q 0
T sys_regs
R 0 01 01
R 3 00 A5
W 0 02 01
R 0 02 01
W 0 02 00
R 0 02 00
T rf_modes
W 1 01 01
P 51
R 1 01 01
W 1 01 02
P 2E
R 1 01 02
W 1 01 03
P 4F
R 1 01 03
W 1 01 00
P 4B
R 1 01 00
R 1 02 1A
T streaming
L 81234567 1
L BAD0FF00 1
L A5A55A5A 1
Q 1
M 81234567 1
M A5A55A5A 1
Q 0
T overflow
L 90004000 17
R 2 01 06
W 2 02 01
R 2 01 02
M 90004000 16
Q 0
T test_mode
W 0 02 01
M 00000000 3
Q 1
